/* Bender.yml */
package:
  name: cr_quantizer

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/quant_pkg.sv
      - verilog/quant_scaler.sv
      - verilog/quant_fifo.sv
      - verilog/quant_rounder.sv
      - verilog/cr_quantizer.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/cr_quantizer_props.sv
      - test/cr_quantizer_tb.sv

/* build.f */
+incdir+verilog
verilog/quant_pkg.sv
verilog/quant_scaler.sv
verilog/quant_fifo.sv
verilog/quant_rounder.sv
verilog/cr_quantizer.sv
test/cr_quantizer_props.sv
test/cr_quantizer_tb.sv

/* test/cr_quantizer_props.sv */
`timescale 1ns/1ps

`include "quant_config.svh"

module cr_quantizer_props import quant_pkg::*; (
	input logic clk,
	input logic rst,
	input logic coef_valid,
	input logic coef_ready,
	input logic out_valid,
	input logic out_ready,
	input coef_t out_coef,
	input logic out_last
);

	localparam int POS_W = $clog2(`QUANT_BLOCK);
	localparam logic [POS_W-1:0] LAST_POS = POS_W'(`QUANT_BLOCK - 1);

	logic seen_accept;
	int unsigned accepted;
	int unsigned delivered;
	int unsigned fail_count = 0;
	logic [POS_W-1:0] out_pos;

	always_ff @(posedge clk) begin
		if (rst) begin
			seen_accept <= 1'b0;
			accepted <= 0;
			delivered <= 0;
			out_pos <= '0;
		end else begin
			if (coef_valid && coef_ready) begin
				seen_accept <= 1'b1;
				accepted <= accepted + 1;
			end
			if (out_valid && out_ready) begin
				delivered <= delivered + 1;
				out_pos <= (out_pos == LAST_POS) ? '0 : out_pos + 1'b1; // Position in block.
			end
		end
	end

	idle_after_reset: assert property (@(posedge clk) disable iff (rst)
		!seen_accept |-> !out_valid && coef_ready)
		else begin
			$error("out_valid or coef_ready wrong before the first accept");
			fail_count++;
		end

	last_every_block: assert property (@(posedge clk) disable iff (rst)
		out_valid && out_ready |-> out_last == (out_pos == LAST_POS))
		else begin
			$error("out_last not on exactly every 64th transfer");
			fail_count++;
		end

	hold_when_stalled: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_coef) && $stable(out_last))
		else begin
			$error("Output changed while stalled");
			fail_count++;
		end

	no_extra_output: assert property (@(posedge clk) disable iff (rst)
		out_valid && out_ready |-> delivered < accepted)
		else begin
			$error("More outputs than accepted inputs");
			fail_count++;
		end

endmodule

bind cr_quantizer cr_quantizer_props cr_quantizer_props_i (.*);

/* test/cr_quantizer_tb.sv */
`timescale 1ns/1ps

`include "quant_config.svh"

module cr_quantizer_tb import quant_pkg::*; ();

	// Four blocks of 64 beats. Gaps add up to 3 cycles a beat and stalls drop
	// out_ready a quarter of the time, so about 700 cycles at worst.
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int READY_BITS = 512;
	localparam coef_t EXTREMES [8] = '{-1024, 1023, 0, -1, 1, -2, 1022, -1023};

	logic clk;
	logic rst;
	logic coef_valid;
	coef_t coef;
	logic coef_ready;
	logic out_valid;
	logic out_ready;
	coef_t out_coef;
	logic out_last;

	int seed;
	int cycle;
	int in_pos;
	int first_accept_cycle;
	int timed_outputs;
	logic timing_check;
	logic stall_mode;
	logic ready_bits [READY_BITS];
	int gap_len [`QUANT_BLOCK];
	coef_t expected_q [$];
	string name_q [$];
	string test_name;

	cr_quantizer cr_quantizer_i (
		.clk(clk),
		.rst(rst),
		.coef_valid(coef_valid),
		.coef(coef),
		.coef_ready(coef_ready),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_coef(out_coef),
		.out_last(out_last)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic value_error(input string name, input int expected, input int actual);
		abort_run($sformatf("Fail %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	// Coefficient times truncated 4096/q, floor shift, plus bit 11.
	function automatic int quantize(input int value, input int pos);
		int recip;
		int product;
		recip = (1 << `QUANT_SHIFT) / int'(cr_divisors[pos]);
		product = value * recip;
		return (product >>> `QUANT_SHIFT) + int'(product[`QUANT_SHIFT-1]);
	endfunction

	task automatic check_output();
		coef_t want;
		string want_name;
		assert (expected_q.size() != 0)
			else abort_run("An output came out with no accepted input behind it");
		want = expected_q.pop_front();
		want_name = name_q.pop_front();
		assert (out_coef == want) else value_error(want_name, int'(want), int'(out_coef));
		if (timing_check) begin
			// Three cycles to the first, then one per cycle.
			assert (cycle == first_accept_cycle + 3 + timed_outputs)
				else value_error("first_block_timing", first_accept_cycle + 3 + timed_outputs,
					cycle);
			timed_outputs++;
		end
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("Timed out after %0d cycles waiting for the DUT", cycle));
		end
		if (cr_quantizer_i.cr_quantizer_props_i.fail_count != 0) begin
			abort_run("A bound property on the DUT ports failed");
		end
		if (!rst && coef_valid && coef_ready) begin
			expected_q.push_back(coef_t'(quantize(int'(coef), in_pos)));
			name_q.push_back(test_name);
			if (timing_check && first_accept_cycle < 0) begin
				first_accept_cycle = cycle;
			end
			in_pos = (in_pos + 1) % `QUANT_BLOCK;
		end
		if (!rst && out_valid && out_ready) begin
			check_output();
		end
	end

	always @(posedge clk) begin
		if (stall_mode) begin
			out_ready <= ready_bits[cycle % READY_BITS];
		end else begin
			out_ready <= 1'b1;
		end
	end

	task automatic send_coef(input coef_t value, input int gap);
		repeat (gap) begin
			coef_valid <= 1'b0;
			@(posedge clk);
		end
		coef_valid <= 1'b1;
		coef <= value;
		@(posedge clk);
		assert (!timing_check || coef_ready)
			else abort_run("coef_ready dropped during continuous traffic with out_ready high");
		while (!coef_ready) begin
			@(posedge clk);
		end
	endtask

	// Negedge keeps the queue check clear of the monitor's edge.
	task automatic drain();
		coef_valid <= 1'b0;
		@(negedge clk);
		while (expected_q.size() != 0) begin
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	initial begin
		seed = 64687;
		rst = 1'b1;
		coef_valid = 1'b0;
		coef = '0;
		out_ready = 1'b0;
		cycle = 0;
		in_pos = 0;
		first_accept_cycle = -1;
		timed_outputs = 0;
		timing_check = 1'b0;
		stall_mode = 1'b0;
		test_name = "reset";
		for (int i = 0; i < READY_BITS; i++) begin
			ready_bits[i] = ($random(seed) & 3) != 0;
		end
		for (int i = 0; i < `QUANT_BLOCK; i++) begin
			gap_len[i] = $random(seed) & 3;
		end

		repeat (8) @(posedge clk);
		rst <= 1'b0;

		test_name <= "continuous";
		timing_check <= 1'b1;
		for (int i = 0; i < `QUANT_BLOCK; i++) begin
			send_coef(coef_t'($random(seed)), 0);
		end
		drain();
		timing_check <= 1'b0;

		test_name <= "stalled";
		stall_mode <= 1'b1; // Random out_ready from here.
		for (int i = 0; i < `QUANT_BLOCK; i++) begin
			send_coef(coef_t'($random(seed)), gap_len[i]);
		end
		drain();
		stall_mode <= 1'b0;

		test_name <= "extremes";
		for (int i = 0; i < `QUANT_BLOCK; i++) begin
			send_coef(EXTREMES[i % 8], 0);
		end
		drain();

		test_name <= "continuous_again";
		for (int i = 0; i < `QUANT_BLOCK; i++) begin
			send_coef(coef_t'($random(seed)), 0);
		end
		drain();

		repeat (2) @(posedge clk);
		if (cr_quantizer_i.cr_quantizer_props_i.fail_count != 0) begin
			abort_run("A bound property on the DUT ports failed at the end of the run");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

/* verilog/cr_quantizer.sv */
`timescale 1ns/1ps

`include "quant_config.svh"

module cr_quantizer import quant_pkg::*; (
	input logic clk,
	input logic rst,
	input logic coef_valid,
	input coef_t coef,
	output logic coef_ready,
	output logic out_valid,
	input logic out_ready,
	output coef_t out_coef,
	output logic out_last
);

	logic push;
	beat_t push_beat;
	logic credit_return;
	logic pop;
	logic not_empty;
	beat_t head;

	quant_scaler quant_scaler_i (
		.clk(clk),
		.rst(rst),
		.coef_valid(coef_valid),
		.coef(coef),
		.coef_ready(coef_ready),
		.credit_return(credit_return),
		.push(push),
		.push_beat(push_beat)
	);

	// Sized to the credit count of the scaler.
	quant_fifo #(
		.DEPTH(`QUANT_FIFO_DEPTH)
	) quant_fifo_i (
		.clk(clk),
		.rst(rst),
		.push(push),
		.push_beat(push_beat),
		.pop(pop),
		.not_empty(not_empty),
		.head(head),
		.credit_return(credit_return)
	);

	quant_rounder quant_rounder_i (
		.clk(clk),
		.rst(rst),
		.not_empty(not_empty),
		.head(head),
		.pop(pop),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_coef(out_coef),
		.out_last(out_last)
	);

endmodule

/* verilog/quant_config.svh */
`ifndef QUANT_CONFIG_SVH
`define QUANT_CONFIG_SVH

// DCT coefficient in, quantized coefficient out.
`define QUANT_COEF_W 11

// Reciprocal of the divisor, 4096 for a divisor of 1.
`define QUANT_RECIP_W 13

// Fraction bits of the reciprocal.
`define QUANT_SHIFT 12

`define QUANT_PROD_W 24 // Signed coefficient times reciprocal.

// One 8x8 block, row-major.
`define QUANT_BLOCK 64

`define QUANT_FIFO_DEPTH 4 // Buffer entries, also producer credits.

`endif

/* verilog/quant_fifo.sv */
`timescale 1ns/1ps

`include "quant_config.svh"

module quant_fifo import quant_pkg::*; #(
	parameter int DEPTH = `QUANT_FIFO_DEPTH
) (
	input logic clk,
	input logic rst,
	input logic push,
	input beat_t push_beat,
	input logic pop,
	output logic not_empty,
	output beat_t head,
	output logic credit_return
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_W = $clog2(DEPTH + 1);

	beat_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [COUNT_W-1:0] count;
	logic do_pop;

	// Wraps for any depth, not only powers of two.
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign not_empty = (count != '0);
	assign head = mem[rd_ptr];
	assign do_pop = pop && not_empty;

	// The producer owns the slot again.
	assign credit_return = do_pop;

	// Credits keep a push from landing on a full buffer.
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_beat;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither.
			endcase
		end
	end

endmodule

/* verilog/quant_pkg.sv */
`include "quant_config.svh"

package quant_pkg;

	typedef logic signed [`QUANT_COEF_W-1:0] coef_t;

	typedef logic [`QUANT_RECIP_W-1:0] recip_t;

	// Same product word, seen as a number or split for rounding.
	typedef union packed {
		logic signed [`QUANT_PROD_W-1:0] raw;
		struct packed {
			logic guard; // Sign copy, dropped.
			logic [`QUANT_COEF_W-1:0] quotient; // Bits 22 to 12.
			logic round; // Bit 11, half of one step.
			logic [`QUANT_SHIFT-2:0] fraction;
		} fields;
	} prod_u;

	typedef struct packed {
		prod_u prod;
		logic last; // Position 63 of the block.
	} beat_t;

	typedef int unsigned divisor_table_t [`QUANT_BLOCK];

	typedef recip_t recip_table_t [`QUANT_BLOCK];

	// Standard JPEG chrominance table, row-major.
	localparam divisor_table_t cr_divisors = '{
		17, 18, 24, 47, 99, 99, 99, 99,
		18, 21, 26, 66, 99, 99, 99, 99,
		24, 26, 56, 99, 99, 99, 99, 99,
		47, 66, 99, 99, 99, 99, 99, 99,
		99, 99, 99, 99, 99, 99, 99, 99,
		99, 99, 99, 99, 99, 99, 99, 99,
		99, 99, 99, 99, 99, 99, 99, 99,
		99, 99, 99, 99, 99, 99, 99, 99
	};

	// Truncated 4096 / q for every position.
	function automatic recip_table_t build_recips();
		recip_table_t table_out;
		for (int i = 0; i < `QUANT_BLOCK; i++) begin
			table_out[i] = recip_t'((1 << `QUANT_SHIFT) / cr_divisors[i]);
		end
		return table_out;
	endfunction

	localparam recip_table_t cr_recips = build_recips();

	// Becomes a 64-entry ROM in the scaler.
	function automatic recip_t recip_of(input int unsigned pos);
		return cr_recips[pos];
	endfunction

endpackage

/* verilog/quant_rounder.sv */
`timescale 1ns/1ps

`include "quant_config.svh"

module quant_rounder import quant_pkg::*; (
	input logic clk,
	input logic rst,
	input logic not_empty,
	input beat_t head,
	output logic pop,
	output logic out_valid,
	input logic out_ready,
	output coef_t out_coef,
	output logic out_last
);

	logic slot_free;
	coef_t rounded;

	// Output register empty, or emptied on this edge.
	assign slot_free = !out_valid || out_ready;
	assign pop = not_empty && slot_free;

	// Round half up on bit 11 of the product.
	assign rounded = coef_t'(head.prod.fields.quotient + head.prod.fields.round);

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (pop) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0; // Taken, nothing behind it.
		end
	end

	// Held while out_ready is low.
	always_ff @(posedge clk) begin
		if (rst) begin
			out_coef <= '0;
			out_last <= 1'b0;
		end else if (pop) begin
			out_coef <= rounded;
			out_last <= head.last;
		end
	end

endmodule

/* verilog/quant_scaler.sv */
`timescale 1ns/1ps

`include "quant_config.svh"

module quant_scaler import quant_pkg::*; (
	input logic clk,
	input logic rst,
	input logic coef_valid,
	input coef_t coef,
	output logic coef_ready,
	input logic credit_return,
	output logic push,
	output beat_t push_beat
);

	localparam int CREDIT_W = $clog2(`QUANT_FIFO_DEPTH + 1);
	localparam int POS_W = $clog2(`QUANT_BLOCK);

	logic [CREDIT_W-1:0] credits;
	logic [POS_W-1:0] pos;
	logic accept;
	logic at_last;
	recip_t recip;
	logic signed [`QUANT_PROD_W-1:0] coef_ext;
	logic signed [`QUANT_PROD_W-1:0] recip_ext;
	prod_u prod;

	// One free slot in the buffer per credit.
	assign coef_ready = (credits != '0);
	assign accept = coef_valid && coef_ready;

	assign at_last = (pos == POS_W'(`QUANT_BLOCK - 1));
	assign recip = recip_of(pos);

	// Two's complement copy of the coefficient.
	assign coef_ext = {{(`QUANT_PROD_W - `QUANT_COEF_W){coef[`QUANT_COEF_W-1]}}, coef};
	assign recip_ext = {{(`QUANT_PROD_W - `QUANT_RECIP_W){1'b0}}, recip}; // Always positive.
	assign prod.raw = coef_ext * recip_ext;

	// Spent on accept, given back one cycle after a pop.
	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= CREDIT_W'(`QUANT_FIFO_DEPTH);
		end else begin
			case ({accept, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pos <= '0;
		end else if (accept) begin
			if (at_last) begin
				pos <= '0; // Next block.
			end else begin
				pos <= pos + 1'b1;
			end
		end
	end

	// Product stage, one cycle from accept to push.
	always_ff @(posedge clk) begin
		if (rst) begin
			push <= 1'b0;
			push_beat <= '0;
		end else begin
			push <= accept;
			if (accept) begin
				push_beat.prod <= prod;
				push_beat.last <= at_last;
			end
		end
	end

endmodule
